// ==== hw/mem_pkg.sv ====
package mem_pkg;

  // ############################
  // command kinds
  // ############################

  // idle must stay zero, the decode register resets to it
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } mem_op_e;

  // ############################
  // default geometry
  // ############################

  // data width in bits
  localparam int DEF_WIDTH = 8;

  // host words, need not be a power of two
  localparam int DEF_NUMADDR = 48;

  // virtual banks, the address is split modulo this
  localparam int DEF_NUMVBNK = 4;

  // cycles from bank read strobe to t1 data
  localparam int DEF_SRAM_DELAY = 1;

endpackage

// ==== hw/mem_stage_if.sv ====
interface mem_stage_if #(
  parameter int WIDTH   = mem_pkg::DEF_WIDTH,
  parameter int BITVBNK = $clog2(mem_pkg::DEF_NUMVBNK),
  parameter int BITVROW = 4
);
  import mem_pkg::*;

  mem_op_e             op;    // idle, read or write
  logic [BITVBNK-1:0]  bank;  // addr modulo banks
  logic [BITVROW-1:0]  row;   // addr divided by banks
  logic [WIDTH-1:0]    bw;
  logic [WIDTH-1:0]    din;

  // decode side
  modport src (
    output op, bank, row, bw, din
  );

  // issue side
  modport dst (
    input op, bank, row, bw, din
  );

endinterface

// ==== hw/rw_decode_stage.sv ====
module rw_decode_stage #(
  parameter int WIDTH   = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK = mem_pkg::DEF_NUMVBNK,
  parameter int BITADDR = $clog2(mem_pkg::DEF_NUMADDR),
  parameter int BITVBNK = $clog2(mem_pkg::DEF_NUMVBNK),
  parameter int BITVROW = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rw_read,
  input  logic               rw_write,
  input  logic [BITADDR-1:0] rw_addr,
  input  logic [WIDTH-1:0]   rw_bw,
  input  logic [WIDTH-1:0]   rw_din,
  mem_stage_if.src           cmd
);
  import mem_pkg::*;

  // NUMADDR <= 2**BITADDR, so one extra bit holds the limit
  localparam logic [BITADDR:0] ADDR_LIMIT = (BITADDR + 1)'(NUMADDR);

  logic               in_range;
  mem_op_e            op_nxt;
  logic [BITVBNK-1:0] bank_nxt;
  logic [BITVROW-1:0] row_nxt;

  // ############################
  // classify and split
  // ############################

  assign in_range = {1'b0, rw_addr} < ADDR_LIMIT;

  always_comb begin
    if (!in_range) begin
      op_nxt = OP_IDLE;  // dropped, nothing reaches the banks
    end else if (rw_write) begin
      op_nxt = OP_WRITE; // write wins over a read in the same cycle
    end else if (rw_read) begin
      op_nxt = OP_READ;
    end else begin
      op_nxt = OP_IDLE;
    end
  end

  // modulo map, works for any bank count
  assign bank_nxt = BITVBNK'(rw_addr % NUMVBNK);
  assign row_nxt  = BITVROW'(rw_addr / NUMVBNK);

  // ############################
  // command register
  // ############################

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.op <= OP_IDLE;
    end else begin
      cmd.op <= op_nxt;
    end
  end

  always_ff @(posedge clk) begin
    cmd.bank <= bank_nxt;
    cmd.row  <= row_nxt;
    cmd.bw   <= rw_bw;
    cmd.din  <= rw_din;
  end

endmodule

// ==== hw/bank_issue_stage.sv ====
module bank_issue_stage #(
  parameter int WIDTH   = mem_pkg::DEF_WIDTH,
  parameter int NUMVBNK = mem_pkg::DEF_NUMVBNK,
  parameter int BITVBNK = $clog2(mem_pkg::DEF_NUMVBNK),
  parameter int BITVROW = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  mem_stage_if.dst                   cmd,
  output logic [NUMVBNK-1:0]         t1_readA,
  output logic [NUMVBNK-1:0]         t1_writeA,
  output logic [NUMVBNK*BITVROW-1:0] t1_addrA,
  output logic [NUMVBNK*WIDTH-1:0]   t1_dinA,
  output logic [NUMVBNK*WIDTH-1:0]   t1_bwA,
  output logic                       rd_tag_vld,
  output logic [BITVBNK-1:0]         rd_tag_bank
);
  import mem_pkg::*;

  logic [NUMVBNK-1:0] bank_sel;
  logic               is_read;
  logic               is_write;

  // bank is always below NUMVBNK, so exactly one bit is set
  assign bank_sel = {{(NUMVBNK - 1){1'b0}}, 1'b1} << cmd.bank;
  assign is_read  = (cmd.op == OP_READ);
  assign is_write = (cmd.op == OP_WRITE);

  // ############################
  // strobes and read tag
  // ############################

  always_ff @(posedge clk) begin
    if (rst) begin
      t1_readA   <= '0;
      t1_writeA  <= '0;
      rd_tag_vld <= 1'b0;
    end else begin
      t1_readA   <= is_read ? bank_sel : '0;
      t1_writeA  <= is_write ? bank_sel : '0;
      rd_tag_vld <= is_read;  // travels next to the read strobe
    end
  end

  // ############################
  // broadcast payload
  // ############################

  // every slice gets the same row, data and mask
  always_ff @(posedge clk) begin
    t1_addrA    <= {NUMVBNK{cmd.row}};
    t1_dinA     <= {NUMVBNK{cmd.din}};
    t1_bwA      <= {NUMVBNK{cmd.bw}};
    rd_tag_bank <= cmd.bank;
  end

endmodule

// ==== hw/read_return_stage.sv ====
module read_return_stage #(
  parameter int WIDTH      = mem_pkg::DEF_WIDTH,
  parameter int NUMVBNK    = mem_pkg::DEF_NUMVBNK,
  parameter int BITVBNK    = $clog2(mem_pkg::DEF_NUMVBNK),
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_tag_vld,
  input  logic [BITVBNK-1:0]       rd_tag_bank,
  input  logic [NUMVBNK*WIDTH-1:0] t1_doutA,
  output logic [WIDTH-1:0]         rw_dout,
  output logic                     rw_vld
);

  logic [SRAM_DELAY-1:0] tag_vld_pipe;
  logic [BITVBNK-1:0]    tag_bank_pipe [SRAM_DELAY];
  logic                  data_rdy;
  logic [WIDTH-1:0]      sel_dout;

  // ############################
  // tag delay line
  // ############################

  // last stage lines up with t1_doutA of the strobed bank
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_vld_pipe <= '0;
    end else begin
      tag_vld_pipe[0] <= rd_tag_vld;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        tag_vld_pipe[i] <= tag_vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    tag_bank_pipe[0] <= rd_tag_bank;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      tag_bank_pipe[i] <= tag_bank_pipe[i-1];
    end
  end

  assign data_rdy = tag_vld_pipe[SRAM_DELAY-1];
  assign sel_dout = t1_doutA[tag_bank_pipe[SRAM_DELAY-1]*WIDTH +: WIDTH];

  // output register, dout holds between reads
  always_ff @(posedge clk) begin
    if (rst) begin
      rw_vld <= 1'b0;
    end else begin
      rw_vld <= data_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (data_rdy) rw_dout <= sel_dout;
  end

endmodule

// ==== hw/algo_1rw_top.sv ====
module algo_1rw_top #(
  parameter int WIDTH      = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK    = mem_pkg::DEF_NUMVBNK,
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY,
  // derived, not meant to be overridden
  parameter int NUMVROW    = (NUMADDR + NUMVBNK - 1) / NUMVBNK,
  parameter int BITADDR    = (NUMADDR > 1) ? $clog2(NUMADDR) : 1,
  parameter int BITVBNK    = $clog2(NUMVBNK),
  parameter int BITVROW    = (NUMVROW > 1) ? $clog2(NUMVROW) : 1
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rw_read,
  input  logic                       rw_write,
  input  logic [BITADDR-1:0]         rw_addr,
  input  logic [WIDTH-1:0]           rw_bw,
  input  logic [WIDTH-1:0]           rw_din,
  output logic [WIDTH-1:0]           rw_dout,
  output logic                       rw_vld,
  output logic [NUMVBNK-1:0]         t1_readA,
  output logic [NUMVBNK-1:0]         t1_writeA,
  output logic [NUMVBNK*BITVROW-1:0] t1_addrA,
  output logic [NUMVBNK*WIDTH-1:0]   t1_dinA,
  output logic [NUMVBNK*WIDTH-1:0]   t1_bwA,
  input  logic [NUMVBNK*WIDTH-1:0]   t1_doutA
);

  logic               rd_tag_vld;
  logic [BITVBNK-1:0] rd_tag_bank;

  mem_stage_if #(.WIDTH(WIDTH), .BITVBNK(BITVBNK), .BITVROW(BITVROW)) stage_if ();

  rw_decode_stage #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK),
    .BITADDR(BITADDR), .BITVBNK(BITVBNK), .BITVROW(BITVROW)
  ) u_decode (
    .clk(clk), .rst(rst), .rw_read(rw_read), .rw_write(rw_write),
    .rw_addr(rw_addr), .rw_bw(rw_bw), .rw_din(rw_din), .cmd(stage_if.src)
  );

  bank_issue_stage #(
    .WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .BITVBNK(BITVBNK), .BITVROW(BITVROW)
  ) u_issue (
    .clk(clk), .rst(rst), .cmd(stage_if.dst),
    .t1_readA(t1_readA), .t1_writeA(t1_writeA), .t1_addrA(t1_addrA),
    .t1_dinA(t1_dinA), .t1_bwA(t1_bwA),
    .rd_tag_vld(rd_tag_vld), .rd_tag_bank(rd_tag_bank)
  );

  read_return_stage #(
    .WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .BITVBNK(BITVBNK), .SRAM_DELAY(SRAM_DELAY)
  ) u_return (
    .clk(clk), .rst(rst), .rd_tag_vld(rd_tag_vld), .rd_tag_bank(rd_tag_bank),
    .t1_doutA(t1_doutA), .rw_dout(rw_dout), .rw_vld(rw_vld)
  );

endmodule

// ==== sim/bank_sram_model.sv ====
module bank_sram_model #(
  parameter int WIDTH      = 8,
  parameter int NUMVBNK    = 4,
  parameter int BITVROW    = 4,
  parameter int SRAM_DELAY = 1
) (
  input  logic                       clk,
  input  logic [NUMVBNK-1:0]         t1_readA,
  input  logic [NUMVBNK-1:0]         t1_writeA,
  input  logic [NUMVBNK*BITVROW-1:0] t1_addrA,
  input  logic [NUMVBNK*WIDTH-1:0]   t1_dinA,
  input  logic [NUMVBNK*WIDTH-1:0]   t1_bwA,
  output logic [NUMVBNK*WIDTH-1:0]   t1_doutA
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUMROW = 2 ** BITVROW;  // full row field, not just the used rows

  logic [WIDTH-1:0]         mem [NUMVBNK][NUMROW];
  logic [NUMVBNK*WIDTH-1:0] rd_pipe [SRAM_DELAY];

  initial begin
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int r = 0; r < NUMROW; r++) begin
        mem[b][r] = '0;
      end
    end
    for (int i = 0; i < SRAM_DELAY; i++) begin
      rd_pipe[i] = '0;
    end
  end

  // bit-writable banks, only the strobed slice acts
  always @(posedge clk) begin
    for (int b = 0; b < NUMVBNK; b++) begin
      if (t1_writeA[b]) begin
        mem[b][t1_addrA[b*BITVROW +: BITVROW]] <=
          (mem[b][t1_addrA[b*BITVROW +: BITVROW]] & ~t1_bwA[b*WIDTH +: WIDTH]) |
          (t1_dinA[b*WIDTH +: WIDTH] & t1_bwA[b*WIDTH +: WIDTH]);
      end
      if (t1_readA[b]) begin
        rd_pipe[0][b*WIDTH +: WIDTH] <= mem[b][t1_addrA[b*BITVROW +: BITVROW]];
      end
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign t1_doutA = rd_pipe[SRAM_DELAY-1];

endmodule

// ==== sim/algo_1rw_asserts.sv ====
module algo_1rw_asserts #(
  parameter int NUMVBNK    = 4,
  parameter int SRAM_DELAY = 1
) (
  input logic               clk,
  input logic               rst,
  input logic [NUMVBNK-1:0] t1_readA,
  input logic [NUMVBNK-1:0] t1_writeA,
  input logic               rw_vld
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LAT = 1 + SRAM_DELAY;  // strobe cycle to valid cycle

  // at most one bank strobed, read or write
  a_strobe_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({t1_readA, t1_writeA}))
    else $error("more than one bank strobe high");

  a_vld_in_rst: assert property (@(posedge clk) rst && $past(rst) |-> !rw_vld)
    else $error("rw_vld high during reset");

  a_read_latency: assert property (@(posedge clk) disable iff (rst)
    (|t1_readA) |-> ##LAT rw_vld)
    else $error("read strobe without rw_vld at fixed latency");

  // no valid without a read strobe behind it
  a_vld_origin: assert property (@(posedge clk) disable iff (rst)
    rw_vld |-> $past(|t1_readA, LAT))
    else $error("rw_vld without matching read strobe");

endmodule

bind algo_1rw_top algo_1rw_asserts #(.NUMVBNK(NUMVBNK), .SRAM_DELAY(SRAM_DELAY)) u_asserts (
  .clk(clk), .rst(rst), .t1_readA(t1_readA), .t1_writeA(t1_writeA), .rw_vld(rw_vld)
);

// ==== sim/tb_algo_1rw.sv ====
module tb_algo_1rw;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int BITADDR     = $clog2(DEF_NUMADDR);
  localparam int BITVROW     = $clog2((DEF_NUMADDR + DEF_NUMVBNK - 1) / DEF_NUMVBNK);
  localparam int DRAIN_LIMIT = 200;

  logic                           clk;
  logic                           rst;
  logic                           rw_read;
  logic                           rw_write;
  logic [BITADDR-1:0]             rw_addr;
  logic [DEF_WIDTH-1:0]           rw_bw;
  logic [DEF_WIDTH-1:0]           rw_din;
  logic [DEF_WIDTH-1:0]           rw_dout;
  logic                           rw_vld;
  logic [DEF_NUMVBNK-1:0]         t1_readA;
  logic [DEF_NUMVBNK-1:0]         t1_writeA;
  logic [DEF_NUMVBNK*BITVROW-1:0] t1_addrA;
  logic [DEF_NUMVBNK*DEF_WIDTH-1:0] t1_dinA;
  logic [DEF_NUMVBNK*DEF_WIDTH-1:0] t1_bwA;
  logic [DEF_NUMVBNK*DEF_WIDTH-1:0] t1_doutA;

  logic [DEF_WIDTH-1:0] exp_q [$];  // expected read data, in issue order
  int                   data_errs = 0;
  int                   other_errs = 0;
  int                   exp_writes = 0;
  int                   seen_writes = 0;
  logic [15:0]          lfsr_state;

  algo_1rw_top DUT (.*);

  bank_sram_model #(
    .WIDTH(DEF_WIDTH), .NUMVBNK(DEF_NUMVBNK), .BITVROW(BITVROW), .SRAM_DELAY(DEF_SRAM_DELAY)
  ) u_sram (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ############################
  // helpers
  // ############################

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic pick_gap(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      n = n * 2 + int'(lfsr_state[0]);
    end
  endtask

  task automatic drive_cmd(input logic rd, input logic wr, input int addr,
                           input logic [DEF_WIDTH-1:0] mask, input logic [DEF_WIDTH-1:0] data);
    @(posedge clk);
    #1;
    rw_read  = rd;
    rw_write = wr;
    rw_addr  = BITADDR'(addr);
    rw_bw    = mask;
    rw_din   = data;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      rw_read  = 1'b0;
      rw_write = 1'b0;
    end
  endtask

  task automatic check_value(input logic [31:0] got,
                             input logic [31:0] want, input string what);
    if (got !== want) begin
      $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, want);
      data_errs++;
    end
  endtask

  // read monitor, sampled away from the rising edge
  always @(negedge clk) begin
    if (!rst && rw_vld) begin
      if (exp_q.size() == 0) begin
        $display("read result %h at %0t arrived with no read outstanding", rw_dout, $time);
        data_errs++;
      end else begin
        check_value(rw_dout, exp_q.pop_front(), "read data");
      end
    end
  end

  // bank write strobes, a dropped write never reaches a bank
  always @(negedge clk) begin
    if (!rst && |t1_writeA) seen_writes++;
  end

  // ############################
  // stimulus
  // ############################

  initial begin
    int                   fd;
    int                   n;
    int                   gap;
    int                   waited;
    string                line;
    logic [7:0]           op_chr;
    int                   addr_val;
    logic [DEF_WIDTH-1:0] mask_val;
    logic [DEF_WIDTH-1:0] data_val;
    logic [DEF_WIDTH-1:0] exp_val;

    rst = 1'b1;
    rw_read = 1'b0;
    rw_write = 1'b0;
    rw_addr = '0;
    rw_bw = '0;
    rw_din = '0;
    lfsr_state = 16'd439;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    fd = $fopen("sim/testdata_rw.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/testdata_rw.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%c %h %h %h %h", op_chr, addr_val, mask_val, data_val, exp_val);
        if (n == 5) begin
          case (op_chr)
            "R", "r": begin
              drive_cmd(1'b1, 1'b0, addr_val, mask_val, data_val);
              if (addr_val < DEF_NUMADDR) exp_q.push_back(exp_val);  // dropped reads expect nothing
            end
            "W", "w": begin
              drive_cmd(1'b0, 1'b1, addr_val, mask_val, data_val);
              if (addr_val < DEF_NUMADDR) exp_writes++;
            end
            "B", "b": begin
              drive_cmd(1'b1, 1'b1, addr_val, mask_val, data_val);  // acts as write
              if (addr_val < DEF_NUMADDR) exp_writes++;
            end
            default: begin
              $display("unknown operation %c in the stimulus file", op_chr);
              other_errs++;
            end
          endcase
          if (op_chr < "a") begin
            pick_gap(gap);
            idle_cycles(gap);
          end
        end
      end
      $fclose(fd);
    end
    idle_cycles(1);

    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out waiting for %0d read results", exp_q.size());
      other_errs++;
    end
    repeat (8) @(posedge clk);  // let a stray valid show up
    check_value(seen_writes, exp_writes, "bank write strobes");

    $display("errors: %0d data, %0d other", data_errs, other_errs);
    if (data_errs == 0 && other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/testdata_rw.txt ====
# op addr mask data expect, all hex; op is R read, W write, B both strobes
# lower case op sends the next command on the very next cycle
W 00 ff 11 00
W 01 ff 22 00
W 02 ff 33 00
W 03 ff 44 00
R 00 ff 00 11
R 01 ff 00 22
R 02 ff 00 33
R 03 ff 00 44
W 02 0f a5 00
R 02 ff 00 35
W 04 ff 40 00
W 05 ff 55 00
W 09 ff 99 00
W 2f ff 7e 00
R 05 ff 00 55
R 09 ff 00 99
R 2f ff 00 7e
R 04 ff 00 40
W 32 ff ee 00
W 3e ff dd 00
R 32 ff 00 00
r 02 ff 00 35
r 06 ff 00 00
r 0a ff 00 00
r 0e ff 00 00
r 12 ff 00 00
r 16 ff 00 00
r 1a ff 00 00
r 1e ff 00 00
r 22 ff 00 00
r 26 ff 00 00
r 2a ff 00 00
R 2e ff 00 00
w 07 ff 70 00
r 07 ff 00 70
b 0a ff 77 00
r 0a ff 00 77
R 03 ff 00 44

// ==== build.f ====
hw/mem_pkg.sv
hw/mem_stage_if.sv
hw/rw_decode_stage.sv
hw/bank_issue_stage.sv
hw/read_return_stage.sv
hw/algo_1rw_top.sv
sim/bank_sram_model.sv
sim/algo_1rw_asserts.sv
sim/tb_algo_1rw.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_algo_1rw
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^All tests passed$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
